// ==== files.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_array_if.sv
hdl/dcache_ways.sv
hdl/dcache_lru.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_dcache || exit 1
OUT="$(./obj_dir/Vtb_dcache)"
echo "$OUT"
echo "$OUT" | grep -qx "TB PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }

// ==== verif/tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache;

    localparam int LINE_BYTES = `DC_LINE_BITS / 8;
    localparam int LINE_SHIFT = $clog2(LINE_BYTES);
    localparam int WORDS      = `DC_LINE_BITS / `DC_XLEN;
    localparam int TAG_LSB    = `DC_XLEN - `DC_TAG_BITS;
    localparam int WAIT_LIMIT = 100;                // Cycles allowed per request

    logic              clk_i;
    logic              rst_i;
    logic              p_strobe_i;
    logic              p_rw_i;
    cache_pkg::addr_t  p_addr_i;
    mem_pkg::byte_en_t p_be_i;
    mem_pkg::word_t    p_data_i;
    mem_pkg::word_t    p_rdata_o;
    logic              p_ready_o;
    logic              m_strobe_o;
    logic              m_rw_o;
    cache_pkg::addr_t  m_addr_o;
    mem_pkg::line_t    m_wdata_o;
    mem_pkg::line_t    m_rdata_i;
    logic              m_ready_i;

    integer            seed;
    int                errors, checks, timeouts;
    int                rd_cnt, wb_cnt;              // Memory strobes seen so far
    cache_pkg::addr_t  exp_fill_addr, exp_wb_addr;  // Predicted memory addresses

    mem_pkg::word_t    ref_words [cache_pkg::addr_t];   // Latest value of each written word
    mem_pkg::word_t    mem_words [cache_pkg::addr_t];   // Words written back to memory

    // Cache model, slot 0 of age_m is the oldest way
    cache_pkg::tag_t   tag_m   [`DC_N_SETS][`DC_N_WAYS];
    logic              valid_m [`DC_N_SETS][`DC_N_WAYS];
    logic              dirty_m [`DC_N_SETS][`DC_N_WAYS];
    int                age_m   [`DC_N_SETS][`DC_N_WAYS];

    dcache_top u_dut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;                  // 8 ns period
    end

    // ====================
    // Models
    // ====================
    // Memory fill pattern, odd multiplier keeps it unique per word address
    function automatic mem_pkg::word_t init_word(cache_pkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A0F_C3E1;
    endfunction

    function automatic mem_pkg::word_t ref_word(cache_pkg::addr_t a);
        return ref_words.exists(a) ? ref_words[a] : init_word(a);
    endfunction

    function automatic mem_pkg::word_t mem_word(cache_pkg::addr_t a);
        return mem_words.exists(a) ? mem_words[a] : init_word(a);
    endfunction

    // What a dirty line must hold when it leaves the cache
    function automatic mem_pkg::line_t ref_line(cache_pkg::addr_t la);
        mem_pkg::line_t l;
        for (int w = 0; w < WORDS; w++)
            l[w * `DC_XLEN +: `DC_XLEN] = ref_word(la + cache_pkg::addr_t'(w * 4));
        return l;
    endfunction

    function automatic mem_pkg::word_t merge_bytes(mem_pkg::word_t old, mem_pkg::word_t d,
                                                   mem_pkg::byte_en_t be);
        mem_pkg::word_t keep;
        keep = '1;
        for (int b = 0; b < `DC_XLEN / 8; b++)
            if (be[b])
                keep[b * 8 +: 8] = 8'h00;           // Lane taken from the write
        return (old & keep) | (d & ~keep);
    endfunction

    function automatic cache_pkg::addr_t make_addr(int tag, int s, int off);
        return (cache_pkg::addr_t'(tag) << TAG_LSB) | (cache_pkg::addr_t'(s) << LINE_SHIFT)
             | cache_pkg::addr_t'(off * 4);
    endfunction

    // Touched way becomes newest, younger ones slide older
    task automatic touch(int s, int way);
        int pos;
        pos = 0;
        for (int i = 0; i < `DC_N_WAYS; i++)
            if (age_m[s][i] == way)
                pos = i;
        for (int i = pos; i < `DC_N_WAYS - 1; i++)
            age_m[s][i] = age_m[s][i + 1];
        age_m[s][`DC_N_WAYS - 1] = way;
    endtask

    task automatic check(input string name, input mem_pkg::line_t got, input mem_pkg::line_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic end_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    // ====================
    // Memory side
    // ====================
    // Counts every strobe even while a request is open
    always @(negedge clk_i)
    begin
        if (m_strobe_o && m_rw_o)
            wb_cnt++;
        else if (m_strobe_o)
            rd_cnt++;
    end

    initial
    begin : memory
        cache_pkg::addr_t la;
        int               delay;
        forever
        begin
            @(negedge clk_i);
            if (m_strobe_o)
            begin
                la = m_addr_o;
                if (m_rw_o)
                begin
                    check("m_addr_o", la, exp_wb_addr);
                    check("m_wdata_o", m_wdata_o, ref_line(la));
                    for (int w = 0; w < WORDS; w++)
                        mem_words[la + cache_pkg::addr_t'(w * 4)] = m_wdata_o[w * 32 +: 32];
                end
                else
                    check("m_addr_o", la, exp_fill_addr);
                delay = 1 + {$random(seed)} % 6;    // 1 to 6 cycles
                repeat (delay) @(posedge clk_i);
                #1;
                m_ready_i = 1'b1;
                for (int w = 0; w < WORDS; w++)
                    m_rdata_i[w * 32 +: 32] = mem_word(la + cache_pkg::addr_t'(w * 4));
                @(posedge clk_i);
                #1;
                m_ready_i = 1'b0;
            end
        end
    end

    // ====================
    // Processor requests
    // ====================
    task automatic access(input cache_pkg::addr_t a, input logic rw, input mem_pkg::byte_en_t be,
                          input mem_pkg::word_t d, output logic hit_seen);
        cache_pkg::addr_t wa;
        cache_pkg::tag_t  tag;
        int               s, way, rd0, wb0, lat;
        logic             hit, wb;
        wa  = a & ~cache_pkg::addr_t'(3);
        tag = cache_pkg::tag_t'(a >> TAG_LSB);
        s   = int'(cache_pkg::set_idx_t'(a >> LINE_SHIFT));
        hit = 1'b0;
        way = 0;
        wb  = 1'b0;
        for (int w = 0; w < `DC_N_WAYS; w++)
            if (valid_m[s][w] && tag_m[s][w] == tag)
            begin
                hit = 1'b1;
                way = w;
            end
        if (!hit)
        begin
            way           = age_m[s][0];            // Oldest way replaced
            wb            = valid_m[s][way] && dirty_m[s][way];
            exp_wb_addr   = (cache_pkg::addr_t'(tag_m[s][way]) << TAG_LSB)
                          | (cache_pkg::addr_t'(s) << LINE_SHIFT);
            exp_fill_addr = a & ~cache_pkg::addr_t'(LINE_BYTES - 1);
            tag_m[s][way]   = tag;
            valid_m[s][way] = 1'b1;
            dirty_m[s][way] = 1'b0;
        end
        if (rw)
        begin
            dirty_m[s][way] = dirty_m[s][way] | (|be);
            ref_words[wa]   = merge_bytes(ref_word(wa), d, be);
        end
        touch(s, way);
        rd0        = rd_cnt;
        wb0        = wb_cnt;
        p_strobe_i = 1'b1;
        p_rw_i     = rw;
        p_addr_i   = a;
        p_be_i     = be;
        p_data_i   = d;
        @(posedge clk_i);                           // Accepting edge
        #1;
        p_strobe_i = 1'b0;
        lat        = 1;
        @(negedge clk_i);
        while (!p_ready_o && lat < WAIT_LIMIT)
        begin
            @(negedge clk_i);
            lat++;
        end
        if (!p_ready_o)
        begin
            timeouts++;
            $display("Timeout: no p_ready_o within %0d cycles for address 0x%h", WAIT_LIMIT, a);
            end_run();
        end
        else
        begin
            hit_seen = (lat == 1) && (rd_cnt == rd0) && (wb_cnt == wb0);
            if (hit)
                check("p_ready_o latency", lat, 1);
            else
            begin
                check("read strobes", rd_cnt - rd0, 1);
                check("write-back strobes", wb_cnt - wb0, wb);
            end
            if (!rw)
                check("p_rdata_o", p_rdata_o, ref_word(wa));
            @(posedge clk_i);
            #1;
        end
    endtask

    initial
    begin
        logic              hit_seen;
        int                tag, s, off, wb0;
        logic              rw;
        mem_pkg::byte_en_t be;
        mem_pkg::word_t    d;
        seed     = 10644;
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        rd_cnt   = 0;
        wb_cnt   = 0;
        rst_i      = 1'b1;
        p_strobe_i = 1'b0;
        p_rw_i     = 1'b0;
        p_addr_i   = '0;
        p_be_i     = '0;
        p_data_i   = '0;
        m_ready_i  = 1'b0;
        m_rdata_i  = '0;
        for (int i = 0; i < `DC_N_SETS; i++)
            for (int w = 0; w < `DC_N_WAYS; w++)
            begin
                tag_m[i][w]   = '0;
                valid_m[i][w] = 1'b0;
                dirty_m[i][w] = 1'b0;
                age_m[i][w]   = w;                  // Way 0 oldest after reset
            end
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        repeat (`DC_N_SETS + 2) @(posedge clk_i);   // Init sweep
        #1;

        // Read miss, repeated hit, partial write then read
        access(make_addr(7, 1, 2), 1'b0, 4'h0, 32'h0, hit_seen);
        check("first read hit", hit_seen, 1'b0);
        access(make_addr(7, 1, 2), 1'b0, 4'h0, 32'h0, hit_seen);
        check("repeated read hit", hit_seen, 1'b1);
        access(make_addr(7, 1, 2), 1'b1, 4'b0101, 32'hDEAD_BEEF, hit_seen);
        access(make_addr(7, 1, 2), 1'b0, 4'h0, 32'h0, hit_seen);

        // LRU order in set 3, tags 16 to 20 stand for A to E
        for (int t = 16; t < 20; t++)
            access(make_addr(t, 3, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        access(make_addr(16, 3, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        check("A hit before E", hit_seen, 1'b1);
        access(make_addr(20, 3, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        check("E hit", hit_seen, 1'b0);
        access(make_addr(16, 3, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        check("A hit after E", hit_seen, 1'b1);
        access(make_addr(17, 3, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        check("B hit after E", hit_seen, 1'b0);

        // Dirty line pushed out of set 5, then read back from memory
        access(make_addr(32, 5, 1), 1'b1, 4'hF, 32'h1234_5678, hit_seen);
        for (int t = 33; t < 36; t++)
            access(make_addr(t, 5, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        wb0 = wb_cnt;
        access(make_addr(36, 5, 0), 1'b0, 4'h0, 32'h0, hit_seen);
        check("write-back count", wb_cnt - wb0, 1);
        access(make_addr(32, 5, 1), 1'b0, 4'h0, 32'h0, hit_seen);

        // Random traffic over three sets and six tags
        for (int i = 0; i < 300; i++)
        begin
            tag = 1 + {$random(seed)} % 6;
            s   = 8 + {$random(seed)} % 3;
            off = {$random(seed)} % 4;
            rw  = $random(seed);
            be  = $random(seed);
            d   = $random(seed);
            access(make_addr(tag, s, off), rw, be, d, hit_seen);
        end
        end_run();
    end

endmodule

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
(
    input  logic              clk_i,
    input  logic              rst_i,
    // Processor side
    input  logic              p_strobe_i,
    input  logic              p_rw_i,
    input  cache_pkg::addr_t  p_addr_i,
    input  mem_pkg::byte_en_t p_be_i,
    input  mem_pkg::word_t    p_data_i,
    output mem_pkg::word_t    p_rdata_o,
    output logic              p_ready_o,
    // Memory side
    output logic              m_strobe_o,
    output logic              m_rw_o,
    output cache_pkg::addr_t  m_addr_o,
    output mem_pkg::line_t    m_wdata_o,
    input  mem_pkg::line_t    m_rdata_i,
    input  logic              m_ready_i
);

    cache_array_if       u_arr ();
    cache_pkg::set_idx_t lru_set;
    logic                lru_touch;
    cache_pkg::way_t     lru_way;
    cache_pkg::way_t     victim_way;     // Oldest way of lru_set

    dcache_ctrl u_ctrl (
        .clk_i, .rst_i,
        .p_strobe_i, .p_rw_i, .p_addr_i, .p_be_i, .p_data_i, .p_rdata_o, .p_ready_o,
        .m_strobe_o, .m_rw_o, .m_addr_o, .m_wdata_o, .m_rdata_i, .m_ready_i,
        .arr          (u_arr.ctrl),
        .lru_set_o    (lru_set),
        .lru_touch_o  (lru_touch),
        .lru_way_o    (lru_way),
        .victim_way_i (victim_way)
    );

    dcache_ways u_ways (.clk_i, .arr(u_arr.ways));

    dcache_lru u_lru (
        .clk_i, .rst_i,
        .set_i       (lru_set),
        .touch_i     (lru_touch),
        .touch_way_i (lru_way),
        .victim_o    (victim_way)
    );

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Processor side
    input  logic                 p_strobe_i,
    input  logic                 p_rw_i,         // 1 for write
    input  cache_pkg::addr_t     p_addr_i,
    input  mem_pkg::byte_en_t    p_be_i,
    input  mem_pkg::word_t       p_data_i,
    output mem_pkg::word_t       p_rdata_o,
    output logic                 p_ready_o,
    // Memory side, whole lines
    output logic                 m_strobe_o,
    output logic                 m_rw_o,
    output cache_pkg::addr_t     m_addr_o,
    output mem_pkg::line_t       m_wdata_o,
    input  mem_pkg::line_t       m_rdata_i,
    input  logic                 m_ready_i,
    // Storage and LRU
    cache_array_if.ctrl          arr,
    output cache_pkg::set_idx_t  lru_set_o,
    output logic                 lru_touch_o,
    output cache_pkg::way_t      lru_way_o,
    input  cache_pkg::way_t      victim_way_i
);

    localparam int OFF_LSB = `DC_BYTE_BITS;
    localparam int SET_LSB = `DC_BYTE_BITS + `DC_WOFF_BITS;

    cache_pkg::ctrl_state_t state_q, state_nxt;
    cache_pkg::set_idx_t    init_cnt_q;     // Init sweep position
    cache_pkg::addr_t       req_addr_q;     // Registered request
    logic                   req_rw_q;
    mem_pkg::byte_en_t      req_be_q;
    mem_pkg::word_t         req_data_q;
    mem_pkg::line_t         fill_line_q;    // Line returned by memory
    logic                   mem_pend_q;     // Strobe sent, no ready yet
    logic                   issue;
    cache_pkg::set_idx_t    p_set, req_set;
    cache_pkg::tag_t        req_tag;
    cache_pkg::word_off_t   req_off;

    assign p_set   = p_addr_i[SET_LSB +: `DC_SET_BITS];
    assign req_set = req_addr_q[SET_LSB +: `DC_SET_BITS];
    assign req_off = req_addr_q[OFF_LSB +: `DC_WOFF_BITS];
    assign req_tag = req_addr_q[`DC_XLEN-1 -: `DC_TAG_BITS];

    function automatic mem_pkg::word_t get_word(mem_pkg::line_t line,
                                                cache_pkg::word_off_t off);
        return line[off * `DC_XLEN +: `DC_XLEN];
    endfunction

    // Enabled bytes come from the processor, the rest stay
    function automatic mem_pkg::line_t merge_word(mem_pkg::line_t line,
                                                  cache_pkg::word_off_t off,
                                                  mem_pkg::word_t data,
                                                  mem_pkg::byte_en_t be);
        mem_pkg::line_t res;
        res = line;
        for (int b = 0; b < `DC_XLEN / 8; b++)
        begin
            if (be[b])
                res[off * `DC_XLEN + b * 8 +: 8] = data[b * 8 +: 8];
        end
        return res;
    endfunction

    // ====================
    // FSM
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q    <= cache_pkg::ST_INIT;
            init_cnt_q <= '0;
        end
        else
        begin
            state_q <= state_nxt;
            if (state_q == cache_pkg::ST_INIT)
                init_cnt_q <= init_cnt_q + 1'b1;
        end
    end

    always_comb
    begin
        state_nxt = state_q;
        unique case (state_q)
            cache_pkg::ST_INIT:
                if (init_cnt_q == cache_pkg::set_idx_t'(`DC_N_SETS - 1))
                    state_nxt = cache_pkg::ST_IDLE;
            cache_pkg::ST_IDLE:
                if (p_strobe_i)
                    state_nxt = cache_pkg::ST_LOOKUP;
            cache_pkg::ST_LOOKUP:
                if (arr.hit)
                    state_nxt = cache_pkg::ST_IDLE;
                else if (arr.victim_valid && arr.victim_dirty)
                    state_nxt = cache_pkg::ST_WB;  // Make room first
                else
                    state_nxt = cache_pkg::ST_FILL;
            cache_pkg::ST_WB:
                if (m_ready_i)
                    state_nxt = cache_pkg::ST_FILL;
            cache_pkg::ST_FILL:
                if (m_ready_i)
                    state_nxt = cache_pkg::ST_FILL_DONE;
            cache_pkg::ST_FILL_DONE:
                state_nxt = cache_pkg::ST_IDLE;
            default:
                state_nxt = cache_pkg::ST_IDLE;
        endcase
    end

    // Request and fill payload
    always_ff @(posedge clk_i)
    begin
        if (state_q == cache_pkg::ST_IDLE && p_strobe_i)
        begin
            req_addr_q <= p_addr_i;
            req_rw_q   <= p_rw_i;
            req_be_q   <= p_be_i;
            req_data_q <= p_data_i;
        end
        if (state_q == cache_pkg::ST_FILL && m_ready_i)
            fill_line_q <= m_rdata_i;
    end

    // ====================
    // Memory requests
    // ====================
    // Strobe lands in the second cycle of WB or FILL
    assign issue = (state_q == cache_pkg::ST_WB || state_q == cache_pkg::ST_FILL)
                && !mem_pend_q && !m_strobe_o;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
            mem_pend_q <= 1'b0;
        end
        else
        begin
            m_strobe_o <= issue;
            if (issue)
                m_rw_o <= (state_q == cache_pkg::ST_WB);
            if (m_ready_i)
                mem_pend_q <= 1'b0;
            else if (m_strobe_o)
                mem_pend_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (issue && state_q == cache_pkg::ST_WB)
        begin
            m_addr_o  <= {arr.victim_tag, req_set, {SET_LSB{1'b0}}};   // Victim's own line
            m_wdata_o <= arr.victim_line;
        end
        else if (issue)
            m_addr_o <= {req_tag, req_set, {SET_LSB{1'b0}}};
    end

    // ====================
    // Storage writes
    // ====================
    assign arr.set_idx    = (state_q == cache_pkg::ST_INIT) ? init_cnt_q
                          : (state_q == cache_pkg::ST_IDLE) ? p_set : req_set;
    assign arr.lookup_tag = req_tag;
    assign arr.clr_valid  = (state_q == cache_pkg::ST_INIT);
    assign arr.victim_way = victim_way_i;

    always_comb
    begin
        arr.wr_mask  = '0;
        arr.wr_tag   = req_tag;
        arr.wr_line  = fill_line_q;
        arr.wr_dirty = 1'b0;
        if (state_q == cache_pkg::ST_LOOKUP && arr.hit && req_rw_q)
        begin
            arr.wr_mask  = cache_pkg::way_mask_t'(1) << arr.hit_way;
            arr.wr_line  = merge_word(arr.hit_line, req_off, req_data_q, req_be_q);
            arr.wr_dirty = arr.hit_dirty | (|req_be_q);   // Empty mask leaves it clean
        end
        else if (state_q == cache_pkg::ST_FILL_DONE)
        begin
            arr.wr_mask  = cache_pkg::way_mask_t'(1) << victim_way_i;
            if (req_rw_q)
                arr.wr_line = merge_word(fill_line_q, req_off, req_data_q, req_be_q);
            arr.wr_dirty = req_rw_q && (|req_be_q);
        end
    end

    // LRU follows the way used
    assign lru_set_o   = req_set;
    assign lru_touch_o = (state_q == cache_pkg::ST_LOOKUP && arr.hit)
                      || (state_q == cache_pkg::ST_FILL_DONE);
    assign lru_way_o   = (state_q == cache_pkg::ST_FILL_DONE) ? victim_way_i : arr.hit_way;

    // Processor answer
    assign p_ready_o = lru_touch_o;
    assign p_rdata_o = (state_q == cache_pkg::ST_FILL_DONE) ? get_word(fill_line_q, req_off)
                                                            : get_word(arr.hit_line, req_off);

    a_strobe_pulse : assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o |=> !m_strobe_o);

    // Memory side is quiet whenever the processor is answered
    a_ready_state : assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_o |-> (state_q == cache_pkg::ST_LOOKUP || state_q == cache_pkg::ST_FILL_DONE)
                      && !m_strobe_o && !mem_pend_q);

endmodule

// ==== hdl/dcache_lru.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_lru
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  cache_pkg::set_idx_t set_i,
    input  logic                touch_i,        // Hit or fill this cycle
    input  cache_pkg::way_t     touch_way_i,
    output cache_pkg::way_t     victim_o
);

    // Slot 0 is the oldest way, the last slot the newest
    cache_pkg::way_t age_q [`DC_N_SETS][`DC_N_WAYS];
    cache_pkg::way_t touch_pos;                 // Slot holding the touched way

    always_comb
    begin
        touch_pos = '0;
        for (int i = 0; i < `DC_N_WAYS; i++)
        begin
            if (age_q[set_i][i] == touch_way_i)
                touch_pos = cache_pkg::way_t'(i);
        end
    end

    // ====================
    // Age update
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_N_SETS; s++)
                for (int i = 0; i < `DC_N_WAYS; i++)
                    age_q[s][i] <= cache_pkg::way_t'(i);  // Way 0 oldest
        end
        else if (touch_i)
        begin
            // Younger ways slide one slot older
            for (int i = 0; i < `DC_N_WAYS - 1; i++)
            begin
                if (i >= touch_pos)
                    age_q[set_i][i] <= age_q[set_i][i + 1];
            end
            age_q[set_i][`DC_N_WAYS - 1] <= touch_way_i;   // Now most recent
        end
    end

    assign victim_o = age_q[set_i][0];

endmodule

// ==== hdl/dcache_ways.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ways
(
    input logic         clk_i,
    cache_array_if.ways arr
);

    // ====================
    // Storage
    // ====================
    cache_pkg::tag_t      tag_mem   [`DC_N_WAYS][`DC_N_SETS];
    mem_pkg::line_t       line_mem  [`DC_N_WAYS][`DC_N_SETS];
    cache_pkg::way_mask_t valid_mem [`DC_N_SETS];    // One bit per way
    cache_pkg::way_mask_t dirty_mem [`DC_N_SETS];

    // Read port registers
    cache_pkg::tag_t      tag_q     [`DC_N_WAYS];
    mem_pkg::line_t       line_q    [`DC_N_WAYS];
    cache_pkg::way_mask_t valid_q;
    cache_pkg::way_mask_t dirty_q;

    cache_pkg::way_mask_t way_hit;

    // Tag and data write, registered read of the addressed set
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            if (arr.wr_mask[w])
            begin
                tag_mem[w][arr.set_idx]  <= arr.wr_tag;
                line_mem[w][arr.set_idx] <= arr.wr_line;
            end
            tag_q[w]  <= tag_mem[w][arr.set_idx];   // Old contents on a write edge
            line_q[w] <= line_mem[w][arr.set_idx];
        end
    end

    // Flag bits, written per set
    always_ff @(posedge clk_i)
    begin
        if (arr.clr_valid)
            valid_mem[arr.set_idx] <= '0;           // Init sweep
        else
            valid_mem[arr.set_idx] <= valid_mem[arr.set_idx] | arr.wr_mask;
        // Written ways take wr_dirty, others keep theirs
        dirty_mem[arr.set_idx] <= (dirty_mem[arr.set_idx] & ~arr.wr_mask)
                                | (arr.wr_mask & {`DC_N_WAYS{arr.wr_dirty}});
        valid_q <= valid_mem[arr.set_idx];
        dirty_q <= dirty_mem[arr.set_idx];
    end

    // ====================
    // Hit detection
    // ====================
    always_comb
    begin
        for (int w = 0; w < `DC_N_WAYS; w++)
            way_hit[w] = valid_q[w] && (tag_q[w] == arr.lookup_tag);
    end

    always_comb
    begin
        arr.hit_way = '0;
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            if (way_hit[w])
                arr.hit_way = cache_pkg::way_t'(w);  // One-hot to binary
        end
    end

    assign arr.hit       = |way_hit;
    assign arr.hit_line  = line_q[arr.hit_way];
    assign arr.hit_dirty = dirty_q[arr.hit_way];

    // Victim view for the write-back decision
    assign arr.victim_valid = valid_q[arr.victim_way];
    assign arr.victim_dirty = dirty_q[arr.victim_way];
    assign arr.victim_tag   = tag_q[arr.victim_way];
    assign arr.victim_line  = line_q[arr.victim_way];

    // A fill never installs a tag that is already valid in the set
    a_one_hit : assert property (@(posedge clk_i)
        !$isunknown(way_hit) |-> $onehot0(way_hit));

endmodule

// ==== hdl/cache_array_if.sv ====
`timescale 1ns/1ps

interface cache_array_if;

    // Controller to storage
    cache_pkg::set_idx_t  set_idx;        // Read and write set
    cache_pkg::tag_t      lookup_tag;     // Tag under test
    cache_pkg::way_mask_t wr_mask;        // Ways written this edge
    cache_pkg::tag_t      wr_tag;
    mem_pkg::line_t       wr_line;
    logic                 wr_dirty;
    cache_pkg::way_t      victim_way;     // From the LRU tracker
    logic                 clr_valid;      // Clears every way of set_idx

    // Storage to controller, one cycle after set_idx
    logic                 hit;
    cache_pkg::way_t      hit_way;
    mem_pkg::line_t       hit_line;
    logic                 hit_dirty;
    logic                 victim_valid;
    logic                 victim_dirty;
    cache_pkg::tag_t      victim_tag;
    mem_pkg::line_t       victim_line;

    modport ctrl (
        output set_idx, lookup_tag, wr_mask, wr_tag, wr_line, wr_dirty, victim_way, clr_valid,
        input  hit, hit_way, hit_line, hit_dirty,
        input  victim_valid, victim_dirty, victim_tag, victim_line
    );

    modport ways (
        input  set_idx, lookup_tag, wr_mask, wr_tag, wr_line, wr_dirty, victim_way, clr_valid,
        output hit, hit_way, hit_line, hit_dirty,
        output victim_valid, victim_dirty, victim_tag, victim_line
    );

endinterface

// ==== hdl/mem_pkg.sv ====
`include "dcache_defs.svh"

package mem_pkg;

    // ====================
    // Data moved
    // ====================
    typedef logic [`DC_XLEN-1:0]      word_t;      // Processor word
    typedef logic [`DC_XLEN/8-1:0]    byte_en_t;   // One bit per byte lane

    // Word 0 sits in the lowest bits
    typedef logic [`DC_LINE_BITS-1:0] line_t;

endpackage

// ==== hdl/cache_pkg.sv ====
`include "dcache_defs.svh"

package cache_pkg;

    // ====================
    // Address fields
    // ====================
    typedef logic [`DC_XLEN-1:0]      addr_t;      // Full byte address
    typedef logic [`DC_TAG_BITS-1:0]  tag_t;       // Bits above the set index
    typedef logic [`DC_SET_BITS-1:0]  set_idx_t;   // Set select
    typedef logic [`DC_WOFF_BITS-1:0] word_off_t;  // Word within a line

    // Way select, binary and one-hot
    typedef logic [`DC_WAY_BITS-1:0]  way_t;
    typedef logic [`DC_N_WAYS-1:0]    way_mask_t;

    // ====================
    // Controller FSM
    // ====================
    typedef enum logic [2:0]
    {
        ST_INIT,        // Valid bits cleared one set per cycle
        ST_IDLE,        // Waits for a processor strobe
        ST_LOOKUP,      // Tags compared, hit answered here
        ST_WB,          // Dirty victim sent to memory
        ST_FILL,        // Line fetched from memory
        ST_FILL_DONE    // Line written into the victim way
    } ctrl_state_t;

endpackage

// ==== hdl/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ====================
// Cache geometry
// ====================
`define DC_XLEN      32     // Processor word width
`define DC_LINE_BITS 128    // One line holds four words
`define DC_N_WAYS    4      // Associativity
`define DC_N_SETS    16     // Sets per way

// Derived address field widths
`define DC_BYTE_BITS ($clog2(`DC_XLEN / 8))
`define DC_WOFF_BITS ($clog2(`DC_LINE_BITS / `DC_XLEN))
`define DC_SET_BITS  ($clog2(`DC_N_SETS))
`define DC_WAY_BITS  ($clog2(`DC_N_WAYS))

// Tag is everything above the set index
`define DC_TAG_BITS  (`DC_XLEN - `DC_SET_BITS - `DC_WOFF_BITS - `DC_BYTE_BITS)

`endif
